// File: flist.f
logic/daq_pkg.sv
logic/sync_fifo.sv
logic/sample_load_fsm.sv
logic/trigger_tracker.sv
logic/channel_capture.sv
logic/daq_event_buffer.sv
sim/tb_daq_event_buffer.sv

// File: logic/channel_capture.sv
`timescale 1ns/1ps

module channel_capture (
	input  logic                          CLK40,
	input  logic                          srst,
	input  logic [2:0]                    sel,
	input  logic                          wr_en,
	input  logic [daq_pkg::bus_w-1:0]     g1_in,
	input  logic [daq_pkg::bus_w-1:0]     g2_in,
	input  logic [daq_pkg::bus_w-1:0]     g3_in,
	input  logic [daq_pkg::bus_w-1:0]     g4_in,
	input  logic [daq_pkg::bus_w-1:0]     g5_in,
	input  logic [daq_pkg::bus_w-1:0]     g6_in,
	input  logic                          data_ready,
	output logic                          data_valid,
	output logic [daq_pkg::bus_w-1:0]     dout_16ch,
	output logic [daq_pkg::ch_fifo_aw:0]  ch_free
);
	import daq_pkg::*;

	logic [bus_w-1:0]    grp_word;        // selected group bus
	logic [n_ch-1:0]     empty;
	logic [ch_fifo_aw:0] free [n_ch];
	logic                pop;

	always_comb begin
		case (sel)
			3'd0:    grp_word = g1_in;
			3'd1:    grp_word = g2_in;
			3'd2:    grp_word = g3_in;
			3'd3:    grp_word = g4_in;
			3'd4:    grp_word = g5_in;
			3'd5:    grp_word = g6_in;
			default: grp_word = '0;
		endcase
	end

	// channels move in lockstep, channel 0 speaks for all
	assign data_valid = !empty[0];
	assign ch_free    = free[0];
	assign pop        = data_valid && data_ready;

	////////////////////////////////////////////////////////////////////////////
	// one FIFO per channel
	////////////////////////////////////////////////////////////////////////////

	for (genvar ch = 0; ch < n_ch; ch++) begin : g_ch
		sync_fifo #(.width(smp_w), .addr_w(ch_fifo_aw)) u_fifo (
			.CLK40 (CLK40),
			.srst  (srst),
			.din   (grp_word[ch*smp_w +: smp_w]),
			.push  (wr_en),
			.pop   (pop),
			.dout  (dout_16ch[ch*smp_w +: smp_w]),
			.empty (empty[ch]),
			.full  (),
			.free  (free[ch])
		);
	end

	a_lockstep: assert property (@(posedge CLK40) disable iff (srst)
		(&empty) || !(|empty));

endmodule

// File: logic/daq_event_buffer.sv
`timescale 1ns/1ps

module daq_event_buffer (
	input  logic                          CLK40,
	input  logic                          srst,
	input  logic                          resync,     // counter clear
	input  logic                          l1a,
	input  logic                          l1a_match,
	input  logic                          smp_stb,
	input  logic [daq_pkg::bus_w-1:0]     g1_in,
	input  logic [daq_pkg::bus_w-1:0]     g2_in,
	input  logic [daq_pkg::bus_w-1:0]     g3_in,
	input  logic [daq_pkg::bus_w-1:0]     g4_in,
	input  logic [daq_pkg::bus_w-1:0]     g5_in,
	input  logic [daq_pkg::bus_w-1:0]     g6_in,
	input  logic [daq_pkg::samp_w-1:0]    samp_max,   // samples per event minus 1
	input  logic                          data_ready,
	output logic                          data_valid,
	output logic [daq_pkg::bus_w-1:0]     dout_16ch,
	input  logic                          hdr_ready,
	output logic                          hdr_valid,
	output logic [daq_pkg::hdr_w-1:0]     hdr_out,
	output logic [7:0]                    drop_cnt
);
	import daq_pkg::*;

	logic                evt_accept;
	logic                evt_reject;
	logic                busy;
	logic [2:0]          sel;
	logic                wr_en;
	logic [ch_fifo_aw:0] ch_free;
	logic                hdr_full;

	sample_load_fsm u_load (
		.CLK40 (CLK40), .srst (srst), .l1a_match (l1a_match), .smp_stb (smp_stb),
		.samp_max (samp_max), .ch_free (ch_free), .hdr_full (hdr_full),
		.evt_accept (evt_accept), .evt_reject (evt_reject), .busy (busy),
		.sel (sel), .wr_en (wr_en)
	);

	trigger_tracker u_trig (
		.CLK40 (CLK40), .srst (srst), .resync (resync), .l1a (l1a),
		.l1a_match (l1a_match), .busy (busy), .evt_accept (evt_accept),
		.evt_reject (evt_reject), .hdr_ready (hdr_ready), .hdr_valid (hdr_valid),
		.hdr_out (hdr_out), .hdr_full (hdr_full), .drop_cnt (drop_cnt)
	);

	channel_capture u_capt (
		.CLK40 (CLK40), .srst (srst), .sel (sel), .wr_en (wr_en),
		.g1_in (g1_in), .g2_in (g2_in), .g3_in (g3_in),
		.g4_in (g4_in), .g5_in (g5_in), .g6_in (g6_in),
		.data_ready (data_ready), .data_valid (data_valid),
		.dout_16ch (dout_16ch), .ch_free (ch_free)
	);

endmodule

// File: logic/daq_pkg.sv
package daq_pkg;

	////////////////////////////////////////////////////////////////////////////
	// channel and group geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int n_ch   = 16;           // channels per group bus
	localparam int n_grp  = 6;            // groups per sample
	localparam int smp_w  = 12;           // one channel word
	localparam int bus_w  = n_ch * smp_w; // 192, group bus and readout word
	localparam int samp_w = 7;            // samp_max width

	////////////////////////////////////////////////////////////////////////////
	// storage depths
	////////////////////////////////////////////////////////////////////////////

	localparam int ch_fifo_aw  = 9;       // 512 words per channel
	localparam int hdr_fifo_aw = 4;       // 16 headers

	////////////////////////////////////////////////////////////////////////////
	// header word layout
	////////////////////////////////////////////////////////////////////////////

	localparam int hdr_w          = 44;
	localparam int l1a_lsb        = 0;
	localparam int l1a_cnt_w      = 24;
	localparam int mtch_lsb       = 24;
	localparam int mtch_cnt_w     = 12;
	localparam int ovlp_lsb       = 36;
	localparam int ovlp_cnt_w     = 4;
	localparam int ovlp_bit       = 40;   // at least one overlap
	localparam int multi_ovlp_bit = 41;   // more than one overlap
	// bits 42 and 43 stay zero

	// load sequencer state codes
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_wait = 2'd1; // waiting for sample strobe
	localparam logic [1:0] st_load = 2'd2; // stepping through groups

endpackage

// File: logic/sample_load_fsm.sv
`timescale 1ns/1ps

module sample_load_fsm (
	input  logic                          CLK40,
	input  logic                          srst,
	input  logic                          l1a_match,
	input  logic                          smp_stb,
	input  logic [daq_pkg::samp_w-1:0]    samp_max,
	input  logic [daq_pkg::ch_fifo_aw:0]  ch_free,
	input  logic                          hdr_full,
	output logic                          evt_accept,
	output logic                          evt_reject,
	output logic                          busy,
	output logic [2:0]                    sel,
	output logic                          wr_en
);
	import daq_pkg::*;

	logic [1:0]          state;
	logic [samp_w-1:0]   sample;          // current sample of event
	logic [samp_w-1:0]   samp_last;       // samp_max held for the event
	logic [ch_fifo_aw:0] need;            // words one event takes
	logic                space_ok;
	logic                idle;

	assign need = ({{(ch_fifo_aw+1-samp_w){1'b0}}, samp_max} + (ch_fifo_aw+1)'(1))
		* (ch_fifo_aw+1)'(n_grp);

	assign idle       = (state == st_idle);
	assign space_ok   = (ch_free >= need) && !hdr_full;
	assign evt_accept = idle && l1a_match && space_ok;
	assign evt_reject = idle && l1a_match && !space_ok;
	assign busy       = !idle;
	assign wr_en      = (state == st_load);

	always_ff @(posedge CLK40) begin
		if (evt_accept)
			samp_last <= samp_max;
	end

	////////////////////////////////////////////////////////////////////////////
	// sequencer: one strobe gives n_grp writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge srst) begin
		if (srst) begin
			state  <= st_idle;
			sel    <= '0;
			sample <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (evt_accept) begin
						state  <= st_wait;
						sample <= '0;
					end
				end
				st_wait: begin
					if (smp_stb)
						state <= st_load;    // writes start next cycle
				end
				st_load: begin
					if (sel == 3'(n_grp - 1)) begin
						sel    <= '0;
						sample <= sample + 1'b1;
						state  <= (sample == samp_last) ? st_idle : st_wait;
					end else begin
						sel <= sel + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// strobe spacing must leave room for all group writes
	a_no_stb_in_load: assert property (@(posedge CLK40) disable iff (srst)
		wr_en |-> !smp_stb);

	// space check at accept covers every write of the event
	a_write_room: assert property (@(posedge CLK40) disable iff (srst)
		wr_en |-> (ch_free != '0));

endmodule

// File: logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int width  = 12,
	parameter int addr_w = 9
) (
	input  logic              CLK40,
	input  logic              srst,
	input  logic [width-1:0]  din,
	input  logic              push,
	input  logic              pop,
	output logic [width-1:0]  dout,
	output logic              empty,
	output logic              full,
	output logic [addr_w:0]   free
);

	logic [width-1:0]  mem [2**addr_w];
	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic [addr_w:0]   cnt;               // occupancy, 0 to depth

	assign dout  = mem[rd_ptr];           // show-ahead
	assign empty = (cnt == '0);
	assign full  = cnt[addr_w];           // only set at depth
	assign free  = {1'b1, {addr_w{1'b0}}} - cnt;

	always_ff @(posedge CLK40) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge CLK40 or posedge srst) begin
		if (srst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
		end
	end

	a_no_underflow: assert property (@(posedge CLK40) disable iff (srst)
		pop |-> !empty);

	a_no_overflow: assert property (@(posedge CLK40) disable iff (srst)
		push |-> !full);

endmodule

// File: logic/trigger_tracker.sv
`timescale 1ns/1ps

module trigger_tracker (
	input  logic                      CLK40,
	input  logic                      srst,
	input  logic                      resync,
	input  logic                      l1a,
	input  logic                      l1a_match,
	input  logic                      busy,
	input  logic                      evt_accept,
	input  logic                      evt_reject,
	input  logic                      hdr_ready,
	output logic                      hdr_valid,
	output logic [daq_pkg::hdr_w-1:0] hdr_out,
	output logic                      hdr_full,
	output logic [7:0]                drop_cnt
);
	import daq_pkg::*;

	logic [l1a_cnt_w-1:0]  l1a_cnt;
	logic [mtch_cnt_w-1:0] mtch_cnt;
	logic [ovlp_cnt_w-1:0] ovlp_cnt;
	logic                  ovlp_in;       // match during a capture
	logic                  hdr_push;      // accept delayed one cycle
	logic                  hdr_empty;
	logic [hdr_w-1:0]      hdr_word;

	assign ovlp_in   = l1a_match && busy;
	assign hdr_valid = !hdr_empty;

	always_ff @(posedge CLK40 or posedge srst) begin
		if (srst)
			hdr_push <= 1'b0;
		else
			hdr_push <= evt_accept;
	end

	////////////////////////////////////////////////////////////////////////////
	// trigger and overlap counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge srst) begin
		if (srst) begin
			l1a_cnt  <= '0;
			mtch_cnt <= '0;
			ovlp_cnt <= '0;
			drop_cnt <= '0;
		end else if (resync) begin
			l1a_cnt  <= '0;
			mtch_cnt <= '0;
			ovlp_cnt <= '0;
			drop_cnt <= '0;
		end else begin
			if (l1a)
				l1a_cnt <= l1a_cnt + 1'b1;   // wraps
			if (l1a_match)
				mtch_cnt <= mtch_cnt + 1'b1;
			if (hdr_push)
				ovlp_cnt <= {{(ovlp_cnt_w-1){1'b0}}, ovlp_in}; // reported, restart
			else if (ovlp_in && ovlp_cnt != '1)
				ovlp_cnt <= ovlp_cnt + 1'b1;
			if (evt_reject && drop_cnt != 8'hff)
				drop_cnt <= drop_cnt + 1'b1;
		end
	end

	// counters already hold the accepting pulse when the push happens
	always_comb begin
		hdr_word = '0;
		hdr_word[l1a_lsb +: l1a_cnt_w]   = l1a_cnt;
		hdr_word[mtch_lsb +: mtch_cnt_w] = mtch_cnt;
		hdr_word[ovlp_lsb +: ovlp_cnt_w] = ovlp_cnt;
		hdr_word[ovlp_bit]               = (ovlp_cnt != '0);
		hdr_word[multi_ovlp_bit]         = (ovlp_cnt > ovlp_cnt_w'(1));
	end

	sync_fifo #(.width(hdr_w), .addr_w(hdr_fifo_aw)) u_hdr_fifo (
		.CLK40 (CLK40),
		.srst  (srst),
		.din   (hdr_word),
		.push  (hdr_push),
		.pop   (hdr_valid && hdr_ready),
		.dout  (hdr_out),
		.empty (hdr_empty),
		.full  (hdr_full),
		.free  ()
	);

	// accept decision must still hold when the header lands
	a_hdr_room: assert property (@(posedge CLK40) disable iff (srst)
		evt_accept |=> !hdr_full);

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_daq_event_buffer \
	-f flist.f --Mdir obj_dir -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "^=== PASS ===$" sim.log &&
{ echo "simulation passed"; exit 0; } ||
{ echo "simulation failed, see sim.log"; exit 1; }

// File: sim/tb_daq_event_buffer.sv
`timescale 1ns/1ps

module tb_daq_event_buffer;
	import daq_pkg::*;

	localparam int max_cycles = 4000;     // about 2000 cycles of tests, doubled

	logic                 CLK40;
	logic                 srst, resync, l1a, l1a_match, smp_stb;
	logic                 data_ready, hdr_ready, data_valid, hdr_valid;
	logic [samp_w-1:0]    samp_max;
	logic [bus_w-1:0]     g_in [n_grp];
	logic [bus_w-1:0]     dout_16ch;
	logic [hdr_w-1:0]     hdr_out;
	logic [7:0]           drop_cnt;

	logic [bus_w-1:0]     data_q [$];     // expected words, sample then group
	logic [hdr_w-1:0]     hdr_q [$];
	logic [31:0]          lcg_state = 32'h394d_1cfd;
	logic [23:0]          l1a_model = '0;
	logic [11:0]          mtch_model = '0;
	logic [7:0]           drop_model = '0;
	logic                 capturing = 1'b0;
	int                   ovlp_model = 0;
	int                   errors = 0;
	int                   cycles = 0;
	int                   data_seen = 0;

	daq_event_buffer u_dut (
		.CLK40 (CLK40), .srst (srst), .resync (resync), .l1a (l1a),
		.l1a_match (l1a_match), .smp_stb (smp_stb),
		.g1_in (g_in[0]), .g2_in (g_in[1]), .g3_in (g_in[2]),
		.g4_in (g_in[3]), .g5_in (g_in[4]), .g6_in (g_in[5]),
		.samp_max (samp_max), .data_ready (data_ready), .data_valid (data_valid),
		.dout_16ch (dout_16ch), .hdr_ready (hdr_ready), .hdr_valid (hdr_valid),
		.hdr_out (hdr_out), .drop_cnt (drop_cnt)
	);

	initial begin
		CLK40 = 1'b0;
		forever #2 CLK40 = ~CLK40;
	end

	always @(posedge CLK40) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run still going after %0d cycles", max_cycles);
			$display("errors: %0d  data words: %0d", errors, data_seen);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_eq(input logic [bus_w-1:0] got, input logic [bus_w-1:0] exp,
		input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED @%0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// readout monitors, half a cycle before the transfer edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge CLK40) begin
		if (data_valid && data_ready) begin
			data_seen++;
			if (data_q.size() == 0) begin
				errors++;
				$display("ERROR @%0t: data word came out with none expected", $time);
			end else
				check_eq(dout_16ch, data_q.pop_front(), "data word");
		end
		if (hdr_valid && hdr_ready) begin
			if (hdr_q.size() == 0) begin
				errors++;
				$display("ERROR @%0t: header came out with none expected", $time);
			end else
				check_eq(hdr_out, hdr_q.pop_front(), "header word");
		end
	end

	task automatic tick(input int n);
		repeat (n) @(posedge CLK40);
	endtask

	task automatic send_l1a(input int n);
		repeat (n) begin
			l1a <= 1'b1;
			tick(1);
			l1a <= 1'b0;
			tick(1);
			l1a_model++;
		end
	endtask

	// l1a with match; outcome follows capture state and the caller's space call
	task automatic send_match(input logic expect_acc);
		logic [hdr_w-1:0] h;
		l1a_model++;
		mtch_model++;
		if (capturing) begin
			if (ovlp_model < 15)
				ovlp_model++;
		end else if (expect_acc) begin
			h = '0;
			h[l1a_lsb +: l1a_cnt_w]   = l1a_model;
			h[mtch_lsb +: mtch_cnt_w] = mtch_model;
			h[ovlp_lsb +: ovlp_cnt_w] = ovlp_model[3:0];
			h[ovlp_bit]               = (ovlp_model > 0);
			h[multi_ovlp_bit]         = (ovlp_model > 1);
			hdr_q.push_back(h);
			ovlp_model = 0;
		end else
			drop_model++;
		l1a       <= 1'b1;
		l1a_match <= 1'b1;
		tick(1);
		l1a       <= 1'b0;
		l1a_match <= 1'b0;
		tick(1);
		check_eq(drop_cnt, drop_model, "drop_cnt after match");
	endtask

	// fresh sample on all six buses, held until the next strobe
	task automatic send_sample();
		logic [bus_w-1:0] w;
		for (int g = 0; g < n_grp; g++) begin
			for (int k = 0; k < bus_w / 32; k++)
				w[k*32 +: 32] = next_rand();
			g_in[g] <= w;
			data_q.push_back(w);
		end
		smp_stb <= 1'b1;
		tick(1);
		smp_stb <= 1'b0;
		tick(7);                          // six writes fit before next strobe
	endtask

	task automatic run_event(input int smax, input int n_ovlp);
		samp_max <= samp_w'(smax);
		send_match(1'b1);
		capturing = 1'b1;
		for (int s = 0; s <= smax; s++) begin
			send_sample();
			if (s == 0)
				repeat (n_ovlp) send_match(1'b0);
		end
		capturing = 1'b0;
	endtask

	task automatic wait_drain();
		while (data_q.size() != 0 || hdr_q.size() != 0)
			tick(1);
		tick(2);
		check_eq(data_valid, 0, "data_valid after drain");
		check_eq(hdr_valid, 0, "hdr_valid after drain");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		check_eq(data_valid, 0, "data_valid after reset");
		check_eq(hdr_valid, 0, "hdr_valid after reset");
		check_eq(drop_cnt, 0, "drop_cnt after reset");
	endtask

	task automatic test_single();
		int start;
		start = data_seen;
		send_l1a(3);                      // l1a and match counts now differ
		run_event(3, 0);
		wait_drain();
		check_eq(data_seen - start, 24, "words of one event");
	endtask

	task automatic test_overlap();
		int start;
		start = data_seen;
		run_event(2, 2);
		run_event(1, 0);                  // its header reports both overlaps
		wait_drain();
		check_eq(data_seen - start, 30, "words of two events");
	endtask

	task automatic test_backpressure();
		logic done;
		int start;
		done = 1'b0;
		start = data_seen;
		fork
			begin
				run_event(7, 0);
				done = 1'b1;
			end
			while (!done || data_q.size() != 0) begin
				data_ready <= 1'b0;
				tick(int'(next_rand() % 24) + 1);
				data_ready <= 1'b1;
				tick(int'(next_rand() % 3) + 1);
			end
		join
		data_ready <= 1'b1;
		wait_drain();
		check_eq(data_seen - start, 48, "words under back-pressure");
	endtask

	task automatic test_drops();
		int start;
		start = data_seen;
		data_ready <= 1'b0;
		run_event(84, 0);                 // 510 of 512 words in use
		tick(4);
		repeat (3) send_match(1'b0);
		data_ready <= 1'b1;
		wait_drain();
		run_event(0, 0);
		wait_drain();
		check_eq(data_seen - start, 516, "words around drops");
	endtask

	task automatic test_resync();
		resync <= 1'b1;
		tick(1);
		resync <= 1'b0;
		tick(1);
		l1a_model  = '0;
		mtch_model = '0;
		drop_model = '0;
		ovlp_model = 0;
		check_eq(drop_cnt, 0, "drop_cnt after resync");
		send_l1a(2);
		run_event(1, 0);
		wait_drain();
	endtask

	initial begin
		srst       = 1'b1;
		resync     = 1'b0;
		l1a        = 1'b0;
		l1a_match  = 1'b0;
		smp_stb    = 1'b0;
		data_ready = 1'b1;
		hdr_ready  = 1'b1;
		samp_max   = '0;
		foreach (g_in[g])
			g_in[g] = '0;
		tick(16);
		srst <= 1'b0;
		tick(2);
		test_reset();
		test_single();
		test_overlap();
		test_backpressure();
		test_drops();
		test_resync();
		tick(4);
		$display("errors: %0d  data words: %0d", errors, data_seen);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
